// ==== design/ex_pkg.sv ====
package ex_pkg;

    // architectural widths
    parameter int DATA_W = 32;
    parameter int REG_W  = 5;

    typedef logic [DATA_W-1:0]   word_t;
    typedef logic [2*DATA_W-1:0] dword_t;
    typedef logic [REG_W-1:0]    reg_num_t;

    // return address target of JAL, BGEZAL and BLTZAL
    parameter reg_num_t LINK_REG = 5'd31;

    // decoded instruction from the decode stage
    typedef enum logic [5:0] {
        OP_NOP,
        // add, subtract, set-less-than
        OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_ADDI, OP_ADDIU,
        OP_SLT, OP_SLTU, OP_SLTI, OP_SLTIU,
        // bitwise
        OP_AND, OP_OR, OP_XOR, OP_NOR,
        OP_ANDI, OP_ORI, OP_XORI, OP_LUI,
        // shifts and counts
        OP_SLL, OP_SRL, OP_SRA, OP_SLLV, OP_SRLV, OP_SRAV,
        OP_CLZ, OP_CLO,
        // multiply, hi/lo and conditional moves
        OP_MUL, OP_MULT, OP_MULTU,
        OP_MFHI, OP_MFLO, OP_MTHI, OP_MTLO,
        OP_MOVZ, OP_MOVN,
        // loads
        OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LWL, OP_LWR,
        // stores
        OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR,
        // link writes
        OP_JAL, OP_JALR, OP_BGEZAL, OP_BLTZAL
    } ex_op_e;

    // direction of the data movement
    typedef enum logic [1:0] {
        MEM_R2R = 2'd0,
        MEM_M2R = 2'd1,
        MEM_R2M = 2'd2
    } mem_type_e;

    // access length, left/right word for the unaligned forms
    typedef enum logic [2:0] {
        MEM_BYTE       = 3'd0,
        MEM_HALF       = 3'd1,
        MEM_WORD       = 3'd2,
        MEM_LEFT_WORD  = 3'd3,
        MEM_RIGHT_WORD = 3'd4
    } mem_size_e;

endpackage

// ==== design/ex_alu_arith.sv ====
`timescale 1ns/1ps

module ex_alu_arith (
    input  ex_pkg::ex_op_e inst_i,
    input  ex_pkg::word_t  reg_s_val_i,
    input  ex_pkg::word_t  reg_t_val_i,
    input  logic [15:0]    immediate_i,
    output ex_pkg::word_t  sum_o,
    output logic           less_o,
    output logic           ovf_trap_o
);
    import ex_pkg::*;

    word_t sext_imm;
    word_t op_b;
    word_t op_b_mux;
    logic  use_imm;
    logic  negate;
    logic  signed_cmp;
    logic  signed_ovf;

    assign sext_imm = {{(DATA_W-16){immediate_i[15]}}, immediate_i};
    assign use_imm  = inst_i inside {OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU};
    assign negate   = inst_i inside {OP_SUB, OP_SUBU, OP_SLT, OP_SLTI};
    assign op_b     = use_imm ? sext_imm : reg_t_val_i;

    // two's complement negate, so one adder covers add, sub and compare
    assign op_b_mux = negate ? (~op_b + word_t'(1)) : op_b;
    assign sum_o    = reg_s_val_i + op_b_mux;

    // signed: differing signs decide directly, else the difference sign
    assign signed_cmp = inst_i inside {OP_SLT, OP_SLTI};
    assign less_o = signed_cmp ?
                    ((reg_s_val_i[DATA_W-1] != op_b[DATA_W-1]) ? reg_s_val_i[DATA_W-1]
                                                               : sum_o[DATA_W-1]) :
                    (reg_s_val_i < op_b);

    // effective operand signs equal but result sign flipped
    assign signed_ovf = (reg_s_val_i[DATA_W-1] == (op_b[DATA_W-1] ^ negate)) &&
                        (sum_o[DATA_W-1] != reg_s_val_i[DATA_W-1]);

    assign ovf_trap_o = (inst_i inside {OP_ADD, OP_SUB, OP_ADDI}) && signed_ovf;

endmodule

// ==== design/ex_logic_shift.sv ====
`timescale 1ns/1ps

module ex_logic_shift (
    input  ex_pkg::ex_op_e inst_i,
    input  ex_pkg::word_t  reg_s_val_i,
    input  ex_pkg::word_t  reg_t_val_i,
    input  logic [15:0]    immediate_i,
    input  logic [4:0]     shift_i,
    output ex_pkg::word_t  logic_o
);
    import ex_pkg::*;

    word_t      zext_imm;
    logic [4:0] shamt;

    // leading zeros from the msb, 32 when the word is all zero
    function automatic logic [5:0] lead_zeros(input word_t v);
        logic [5:0] n;
        logic       hit;
        n   = 6'd0;
        hit = 1'b0;
        for (int i = DATA_W - 1; i >= 0; i--)
        begin
            if (v[i])
                hit = 1'b1;
            else if (!hit)
                n = n + 6'd1;
        end
        return n;
    endfunction

    assign zext_imm = {{(DATA_W-16){1'b0}}, immediate_i};

    // variable forms take the amount from rs
    assign shamt = (inst_i inside {OP_SLLV, OP_SRLV, OP_SRAV}) ? reg_s_val_i[4:0] : shift_i;

    always_comb
    begin
        case (inst_i)
            OP_AND:  logic_o = reg_s_val_i & reg_t_val_i;
            OP_OR:   logic_o = reg_s_val_i | reg_t_val_i;
            OP_XOR:  logic_o = reg_s_val_i ^ reg_t_val_i;
            OP_NOR:  logic_o = ~(reg_s_val_i | reg_t_val_i);
            OP_ANDI: logic_o = reg_s_val_i & zext_imm;
            OP_ORI:  logic_o = reg_s_val_i | zext_imm;
            OP_XORI: logic_o = reg_s_val_i ^ zext_imm;
            OP_LUI:  logic_o = {immediate_i, 16'h0000};
            OP_SLL, OP_SLLV: logic_o = reg_t_val_i << shamt;
            OP_SRL, OP_SRLV: logic_o = reg_t_val_i >> shamt;
            // sign bit fills from the top
            OP_SRA, OP_SRAV: logic_o = word_t'($signed(reg_t_val_i) >>> shamt);
            OP_CLZ:  logic_o = word_t'(lead_zeros(reg_s_val_i));
            // count ones as zeros of the inverse
            OP_CLO:  logic_o = word_t'(lead_zeros(~reg_s_val_i));
            default: logic_o = '0;
        endcase
    end

endmodule

// ==== design/ex_multiplier.sv ====
`timescale 1ns/1ps

module ex_multiplier (
    input  ex_pkg::ex_op_e inst_i,
    input  ex_pkg::word_t  reg_s_val_i,
    input  ex_pkg::word_t  reg_t_val_i,
    output ex_pkg::dword_t product_o
);
    import ex_pkg::*;

    logic   is_signed;
    logic   neg_result;
    word_t  mag_s;
    word_t  mag_t;
    dword_t mag_product;

    assign is_signed = inst_i inside {OP_MUL, OP_MULT};

    // magnitudes for the signed forms, raw operands for multu
    assign mag_s = (is_signed && reg_s_val_i[DATA_W-1]) ? (~reg_s_val_i + word_t'(1))
                                                        : reg_s_val_i;
    assign mag_t = (is_signed && reg_t_val_i[DATA_W-1]) ? (~reg_t_val_i + word_t'(1))
                                                        : reg_t_val_i;

    assign mag_product = dword_t'(mag_s) * dword_t'(mag_t);

    // restore the sign when the operand signs differ
    assign neg_result = is_signed && (reg_s_val_i[DATA_W-1] ^ reg_t_val_i[DATA_W-1]);
    assign product_o  = neg_result ? (~mag_product + dword_t'(1)) : mag_product;

endmodule

// ==== design/ex_mem_access.sv ====
`timescale 1ns/1ps

module ex_mem_access (
    input  ex_pkg::ex_op_e    inst_i,
    input  ex_pkg::word_t     reg_s_val_i,
    input  logic [15:0]       immediate_i,
    output ex_pkg::word_t     mem_addr_c_o,
    output ex_pkg::mem_type_e mem_type_c_o,
    output ex_pkg::mem_size_e mem_size_c_o,
    output logic              mem_signed_c_o
);
    import ex_pkg::*;

    logic  is_load;
    logic  is_store;
    word_t sext_imm;

    assign is_load  = inst_i inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LWL, OP_LWR};
    assign is_store = inst_i inside {OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR};
    assign sext_imm = {{(DATA_W-16){immediate_i[15]}}, immediate_i};

    // base plus offset, zero when no access
    assign mem_addr_c_o = (is_load || is_store) ? (reg_s_val_i + sext_imm) : '0;

    assign mem_type_c_o = is_load  ? MEM_M2R :
                          is_store ? MEM_R2M : MEM_R2R;

    always_comb
    begin
        case (inst_i)
            OP_LB, OP_LBU, OP_SB: mem_size_c_o = MEM_BYTE;
            OP_LH, OP_LHU, OP_SH: mem_size_c_o = MEM_HALF;
            OP_LWL, OP_SWL:       mem_size_c_o = MEM_LEFT_WORD;
            OP_LWR, OP_SWR:       mem_size_c_o = MEM_RIGHT_WORD;
            default:              mem_size_c_o = MEM_WORD;
        endcase
    end

    // only the unsigned sub-word loads skip sign extension
    assign mem_signed_c_o = !(inst_i inside {OP_LBU, OP_LHU});

endmodule

// ==== design/ex_writeback.sv ====
`timescale 1ns/1ps

module ex_writeback (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              valid_i,
    input  ex_pkg::ex_op_e    inst_i,
    input  ex_pkg::word_t     reg_s_val_i,
    input  ex_pkg::word_t     reg_t_val_i,
    input  ex_pkg::reg_num_t  reg_d_i,
    input  ex_pkg::reg_num_t  reg_t_i,
    input  ex_pkg::word_t     return_addr_i,
    input  ex_pkg::dword_t    hilo_i,
    input  ex_pkg::word_t     sum_i,
    input  logic              less_i,
    input  logic              ovf_trap_i,
    input  ex_pkg::word_t     logic_i,
    input  ex_pkg::dword_t    product_i,
    input  ex_pkg::word_t     mem_addr_c_i,
    input  ex_pkg::mem_type_e mem_type_c_i,
    input  ex_pkg::mem_size_e mem_size_c_i,
    input  logic              mem_signed_c_i,
    output logic              valid_o,
    output ex_pkg::word_t     val_o,
    output ex_pkg::reg_num_t  dest_reg_o,
    output logic              overflow_o,
    output ex_pkg::dword_t    hilo_o,
    output logic              hilo_we_o,
    output ex_pkg::word_t     mem_addr_o,
    output ex_pkg::mem_type_e mem_type_o,
    output ex_pkg::mem_size_e mem_size_o,
    output logic              mem_signed_o
);
    import ex_pkg::*;

    word_t    val_c;
    reg_num_t dest_c;
    dword_t   hilo_c;
    logic     hilo_we_c;

    always_comb
    begin
        val_c     = '0;
        dest_c    = '0;
        hilo_c    = '0;
        hilo_we_c = 1'b0;
        case (inst_i)
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU:
            begin
                val_c  = sum_i;
                dest_c = reg_d_i;
            end
            OP_ADDI, OP_ADDIU:
            begin
                val_c  = sum_i;
                dest_c = reg_t_i;
            end
            OP_SLT, OP_SLTU:
            begin
                val_c  = word_t'(less_i);
                dest_c = reg_d_i;
            end
            OP_SLTI, OP_SLTIU:
            begin
                val_c  = word_t'(less_i);
                dest_c = reg_t_i;
            end
            OP_AND, OP_OR, OP_XOR, OP_NOR, OP_SLL, OP_SRL, OP_SRA,
            OP_SLLV, OP_SRLV, OP_SRAV, OP_CLZ, OP_CLO:
            begin
                val_c  = logic_i;
                dest_c = reg_d_i;
            end
            OP_ANDI, OP_ORI, OP_XORI, OP_LUI:
            begin
                val_c  = logic_i;
                dest_c = reg_t_i;
            end
            OP_MUL:
            begin
                val_c  = product_i[DATA_W-1:0];
                dest_c = reg_d_i;
            end
            OP_MULT, OP_MULTU:
            begin
                hilo_c    = product_i;
                hilo_we_c = 1'b1;
            end
            OP_MFHI:
            begin
                val_c  = hilo_i[2*DATA_W-1:DATA_W];
                dest_c = reg_d_i;
            end
            OP_MFLO:
            begin
                val_c  = hilo_i[DATA_W-1:0];
                dest_c = reg_d_i;
            end
            // the untouched half passes through
            OP_MTHI:
            begin
                hilo_c    = {reg_s_val_i, hilo_i[DATA_W-1:0]};
                hilo_we_c = 1'b1;
            end
            OP_MTLO:
            begin
                hilo_c    = {hilo_i[2*DATA_W-1:DATA_W], reg_s_val_i};
                hilo_we_c = 1'b1;
            end
            OP_MOVZ:
            begin
                val_c  = reg_s_val_i;
                dest_c = (reg_t_val_i == '0) ? reg_d_i : '0;
            end
            OP_MOVN:
            begin
                val_c  = reg_s_val_i;
                dest_c = (reg_t_val_i != '0) ? reg_d_i : '0;
            end
            // rt value rides along for loads and stores
            OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LWL, OP_LWR,
            OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR:
            begin
                val_c  = reg_t_val_i;
                dest_c = reg_t_i;
            end
            OP_JAL, OP_BGEZAL, OP_BLTZAL:
            begin
                val_c  = return_addr_i;
                dest_c = LINK_REG;
            end
            OP_JALR:
            begin
                val_c  = return_addr_i;
                dest_c = reg_d_i;
            end
            default:
            begin
                val_c  = '0;
                dest_c = '0;
            end
        endcase
        // trap squashes the register write
        if (ovf_trap_i)
        begin
            val_c  = '0;
            dest_c = '0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            valid_o    <= 1'b0;
            val_o      <= '0;
            dest_reg_o <= '0;
            overflow_o <= 1'b0;
            hilo_o     <= '0;
            hilo_we_o  <= 1'b0;
            mem_type_o <= MEM_R2R;
        end
        else
        begin
            valid_o    <= valid_i;
            val_o      <= val_c;
            dest_reg_o <= valid_i ? dest_c : '0;
            overflow_o <= valid_i && ovf_trap_i;
            hilo_o     <= hilo_c;
            hilo_we_o  <= valid_i && hilo_we_c;
            mem_type_o <= valid_i ? mem_type_c_i : MEM_R2R;
        end
    end

    // address and attributes only matter alongside mem_type_o
    always_ff @(posedge clk)
    begin
        mem_addr_o   <= mem_addr_c_i;
        mem_size_o   <= mem_size_c_i;
        mem_signed_o <= mem_signed_c_i;
    end

    // hi/lo writes never also target a gpr
    assert property (@(posedge clk) disable iff (!rst_n) hilo_we_o |-> (dest_reg_o == '0))
    else $error("hilo write with nonzero destination");

    // only the trapping signed forms may raise overflow
    assert property (@(posedge clk) disable iff (!rst_n)
                     overflow_o |-> $past(inst_i inside {OP_ADD, OP_SUB, OP_ADDI}))
    else $error("overflow on a non-trapping opcode");

endmodule

// ==== design/ex_stage.sv ====
`timescale 1ns/1ps

module ex_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              valid_i,
    input  ex_pkg::ex_op_e    inst_i,
    input  ex_pkg::word_t     reg_s_val_i,
    input  ex_pkg::word_t     reg_t_val_i,
    input  ex_pkg::reg_num_t  reg_d_i,
    input  ex_pkg::reg_num_t  reg_t_i,
    input  logic [15:0]       immediate_i,
    input  logic [4:0]        shift_i,
    input  ex_pkg::word_t     return_addr_i,
    input  ex_pkg::dword_t    hilo_i,
    output logic              valid_o,
    output ex_pkg::word_t     val_o,
    output ex_pkg::reg_num_t  dest_reg_o,
    output logic              overflow_o,
    output ex_pkg::dword_t    hilo_o,
    output logic              hilo_we_o,
    output ex_pkg::word_t     mem_addr_o,
    output ex_pkg::mem_type_e mem_type_o,
    output ex_pkg::mem_size_e mem_size_o,
    output logic              mem_signed_o
);
    import ex_pkg::*;

    // operand unit results, all settle within the issue cycle
    word_t     sum;
    logic      less;
    logic      ovf_trap;
    word_t     logic_res;
    dword_t    product;
    word_t     mem_addr_c;
    mem_type_e mem_type_c;
    mem_size_e mem_size_c;
    logic      mem_signed_c;

    ex_alu_arith u_alu_arith (
        .inst_i      (inst_i),
        .reg_s_val_i (reg_s_val_i),
        .reg_t_val_i (reg_t_val_i),
        .immediate_i (immediate_i),
        .sum_o       (sum),
        .less_o      (less),
        .ovf_trap_o  (ovf_trap)
    );

    ex_logic_shift u_logic_shift (
        .inst_i      (inst_i),
        .reg_s_val_i (reg_s_val_i),
        .reg_t_val_i (reg_t_val_i),
        .immediate_i (immediate_i),
        .shift_i     (shift_i),
        .logic_o     (logic_res)
    );

    ex_multiplier u_multiplier (
        .inst_i      (inst_i),
        .reg_s_val_i (reg_s_val_i),
        .reg_t_val_i (reg_t_val_i),
        .product_o   (product)
    );

    ex_mem_access u_mem_access (
        .inst_i         (inst_i),
        .reg_s_val_i    (reg_s_val_i),
        .immediate_i    (immediate_i),
        .mem_addr_c_o   (mem_addr_c),
        .mem_type_c_o   (mem_type_c),
        .mem_size_c_o   (mem_size_c),
        .mem_signed_c_o (mem_signed_c)
    );

    ex_writeback u_writeback (
        .clk            (clk),
        .rst_n          (rst_n),
        .valid_i        (valid_i),
        .inst_i         (inst_i),
        .reg_s_val_i    (reg_s_val_i),
        .reg_t_val_i    (reg_t_val_i),
        .reg_d_i        (reg_d_i),
        .reg_t_i        (reg_t_i),
        .return_addr_i  (return_addr_i),
        .hilo_i         (hilo_i),
        .sum_i          (sum),
        .less_i         (less),
        .ovf_trap_i     (ovf_trap),
        .logic_i        (logic_res),
        .product_i      (product),
        .mem_addr_c_i   (mem_addr_c),
        .mem_type_c_i   (mem_type_c),
        .mem_size_c_i   (mem_size_c),
        .mem_signed_c_i (mem_signed_c),
        .valid_o        (valid_o),
        .val_o          (val_o),
        .dest_reg_o     (dest_reg_o),
        .overflow_o     (overflow_o),
        .hilo_o         (hilo_o),
        .hilo_we_o      (hilo_we_o),
        .mem_addr_o     (mem_addr_o),
        .mem_type_o     (mem_type_o),
        .mem_size_o     (mem_size_o),
        .mem_signed_o   (mem_signed_o)
    );

endmodule

// ==== sim/tb_ex_stage.sv ====
`timescale 1ns/1ps

module tb_ex_stage;
    import ex_pkg::*;

    localparam reg_num_t RD_NUM        = 5'd3;
    localparam reg_num_t RT_NUM        = 5'd7;
    localparam word_t    RET_ADDR      = 32'h0040_1008;
    localparam dword_t   HILO_IN       = 64'h1111_2222_3333_4444;
    localparam int       RESET_CYCLES  = 16;
    localparam int       RESET_TIMEOUT = 100;
    localparam int       BURST_LEN     = 64;

    // one table row: stimulus followed by expected outputs
    typedef struct packed {
        ex_op_e    op;
        word_t     rs;
        word_t     rt;
        reg_num_t  rd;
        reg_num_t  rtn;
        logic [15:0] imm;
        logic [4:0]  sh;
        word_t     ra;
        dword_t    hilo;
        word_t     e_val;
        reg_num_t  e_dest;
        logic      e_ovf;
        logic      e_we;
        dword_t    e_hilo;
        mem_type_e e_type;
        mem_size_e e_size;
        logic      e_sgn;
        word_t     e_addr;
    } entry_t;

    logic        clk;
    logic        rst_n;
    logic        valid_i;
    ex_op_e      inst_i;
    word_t       reg_s_val_i;
    word_t       reg_t_val_i;
    reg_num_t    reg_d_i;
    reg_num_t    reg_t_i;
    logic [15:0] immediate_i;
    logic [4:0]  shift_i;
    word_t       return_addr_i;
    dword_t      hilo_i;
    logic        valid_o;
    word_t       val_o;
    reg_num_t    dest_reg_o;
    logic        overflow_o;
    dword_t      hilo_o;
    logic        hilo_we_o;
    word_t       mem_addr_o;
    mem_type_e   mem_type_o;
    mem_size_e   mem_size_o;
    logic        mem_signed_o;

    entry_t      tbl [0:127];
    int          n_entries;
    logic [15:0] lfsr;
    int          wait_cnt;
    word_t       pick;
    word_t       rnd_a;
    word_t       rnd_b;
    word_t       rnd_r;
    ex_op_e      rnd_op;

    ex_stage u_ex_stage (
        .clk           (clk),
        .rst_n         (rst_n),
        .valid_i       (valid_i),
        .inst_i        (inst_i),
        .reg_s_val_i   (reg_s_val_i),
        .reg_t_val_i   (reg_t_val_i),
        .reg_d_i       (reg_d_i),
        .reg_t_i       (reg_t_i),
        .immediate_i   (immediate_i),
        .shift_i       (shift_i),
        .return_addr_i (return_addr_i),
        .hilo_i        (hilo_i),
        .valid_o       (valid_o),
        .val_o         (val_o),
        .dest_reg_o    (dest_reg_o),
        .overflow_o    (overflow_o),
        .hilo_o        (hilo_o),
        .hilo_we_o     (hilo_we_o),
        .mem_addr_o    (mem_addr_o),
        .mem_type_o    (mem_type_o),
        .mem_size_o    (mem_size_o),
        .mem_signed_o  (mem_signed_o)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial
    begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
    end

    task automatic report_error(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        $display("tests failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp)
            report_error($sformatf("%s: got %h expected %h", what, got, exp));
    endtask

    task automatic check_reg(input reg_num_t got, input reg_num_t exp, input string what);
        if (got !== exp)
            report_error($sformatf("%s: got %0d expected %0d", what, got, exp));
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
            report_error($sformatf("%s: got %b expected %b", what, got, exp));
    endtask

    task automatic check_hilo(input dword_t got, input logic got_we,
                              input dword_t exp, input logic exp_we, input string what);
        if (got_we !== exp_we || got !== exp)
            report_error($sformatf("%s: got %h we %b expected %h we %b",
                                   what, got, got_we, exp, exp_we));
    endtask

    task automatic check_mem(input mem_type_e got_t, input mem_size_e got_s, input logic got_sg,
                             input mem_type_e exp_t, input mem_size_e exp_s, input logic exp_sg,
                             input string what);
        if (got_t !== exp_t || got_s !== exp_s || got_sg !== exp_sg)
            report_error($sformatf("%s mem attrs: got %s/%s/%b expected %s/%s/%b", what,
                                   got_t.name(), got_s.name(), got_sg,
                                   exp_t.name(), exp_s.name(), exp_sg));
    endtask

    // 16-bit fibonacci lfsr, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic take_bits(input int n, output word_t v);
        v = '0;
        for (int k = 0; k < n; k++)
        begin
            lfsr = lfsr_step(lfsr);
            v    = {v[DATA_W-2:0], lfsr[0]};
        end
    endtask

    // reference for the random burst
    function automatic word_t model_alu(input ex_op_e op, input word_t a, input word_t b);
        if (op == OP_XOR)
            return a ^ b;
        return a + b;
    endfunction

    // a nop with the quiet output state it should produce
    function automatic entry_t default_entry();
        entry_t e;
        e        = '0;
        e.op     = OP_NOP;
        e.rd     = RD_NUM;
        e.rtn    = RT_NUM;
        e.ra     = RET_ADDR;
        e.hilo   = HILO_IN;
        e.e_type = MEM_R2R;
        e.e_size = MEM_WORD;
        e.e_sgn  = 1'b1;
        return e;
    endfunction

    task automatic stim(input ex_op_e op, input word_t rs, input word_t rt,
                        input logic [15:0] imm, input logic [4:0] sh);
        tbl[n_entries]     = default_entry();
        tbl[n_entries].op  = op;
        tbl[n_entries].rs  = rs;
        tbl[n_entries].rt  = rt;
        tbl[n_entries].imm = imm;
        tbl[n_entries].sh  = sh;
        n_entries++;
    endtask

    task automatic expect_reg(input word_t v, input reg_num_t d);
        tbl[n_entries-1].e_val  = v;
        tbl[n_entries-1].e_dest = d;
    endtask

    task automatic expect_hilo(input dword_t h);
        tbl[n_entries-1].e_we   = 1'b1;
        tbl[n_entries-1].e_hilo = h;
    endtask

    task automatic mem_case(input ex_op_e op, input logic [15:0] imm, input word_t addr,
                            input mem_type_e t, input mem_size_e s, input logic sg);
        stim(op, 32'h1000_0000, 32'hDEAD_BEEF, imm, '0);
        expect_reg(32'hDEAD_BEEF, RT_NUM);
        tbl[n_entries-1].e_type = t;
        tbl[n_entries-1].e_size = s;
        tbl[n_entries-1].e_sgn  = sg;
        tbl[n_entries-1].e_addr = addr;
    endtask

    task automatic build_table();
        // arithmetic, wrap and trap
        stim(OP_ADDU, 32'hFFFF_FFFF, 32'h2, '0, '0);         expect_reg(32'h1, RD_NUM);
        stim(OP_SUBU, 32'h0, 32'h1, '0, '0);                 expect_reg(32'hFFFF_FFFF, RD_NUM);
        stim(OP_ADDIU, 32'hFFFF_FFF0, '0, 16'h0020, '0);     expect_reg(32'h10, RT_NUM);
        stim(OP_ADD, 32'h5, 32'h7, '0, '0);                  expect_reg(32'hC, RD_NUM);
        stim(OP_ADD, 32'h7FFF_FFFF, 32'h1, '0, '0);          tbl[n_entries-1].e_ovf = 1'b1;
        stim(OP_SUB, 32'h7FFF_FFFF, 32'hFFFF_FFFF, '0, '0);  tbl[n_entries-1].e_ovf = 1'b1;
        stim(OP_ADDI, 32'h7FFF_FFFF, '0, 16'h0001, '0);      tbl[n_entries-1].e_ovf = 1'b1;
        stim(OP_SLT, 32'hFFFF_FFFF, 32'h1, '0, '0);          expect_reg(32'h1, RD_NUM);
        stim(OP_SLTU, 32'hFFFF_FFFF, 32'h1, '0, '0);         expect_reg(32'h0, RD_NUM);
        stim(OP_SLTI, 32'hFFFF_FFFE, '0, 16'hFFFF, '0);      expect_reg(32'h1, RT_NUM);
        stim(OP_SLTIU, 32'h5, '0, 16'hFFFF, '0);             expect_reg(32'h1, RT_NUM);
        // logic and shifts
        stim(OP_AND, 32'hF0F0_1234, 32'h0FF0_FF00, '0, '0);  expect_reg(32'h00F0_1200, RD_NUM);
        stim(OP_OR, 32'hF000_0000, 32'h0000_000F, '0, '0);   expect_reg(32'hF000_000F, RD_NUM);
        stim(OP_XOR, 32'hAAAA_5555, 32'hFFFF_0000, '0, '0);  expect_reg(32'h5555_5555, RD_NUM);
        stim(OP_NOR, 32'h0F0F_0000, 32'h0000_F0F0, '0, '0);  expect_reg(32'hF0F0_0F0F, RD_NUM);
        stim(OP_ANDI, 32'hFFFF_FFFF, '0, 16'h8001, '0);      expect_reg(32'h0000_8001, RT_NUM);
        stim(OP_ORI, 32'h1234_0000, '0, 16'h8000, '0);       expect_reg(32'h1234_8000, RT_NUM);
        stim(OP_XORI, 32'hFFFF_FFFF, '0, 16'h00FF, '0);      expect_reg(32'hFFFF_FF00, RT_NUM);
        stim(OP_LUI, '0, '0, 16'hBEEF, '0);                  expect_reg(32'hBEEF_0000, RT_NUM);
        stim(OP_SLL, '0, 32'h1, '0, 5'd31);                  expect_reg(32'h8000_0000, RD_NUM);
        stim(OP_SRL, '0, 32'h8000_0000, '0, 5'd4);           expect_reg(32'h0800_0000, RD_NUM);
        stim(OP_SRA, '0, 32'h8000_0000, '0, 5'd4);           expect_reg(32'hF800_0000, RD_NUM);
        stim(OP_SLLV, 32'h24, 32'hFF, '0, '0);               expect_reg(32'h0000_0FF0, RD_NUM);
        stim(OP_SRLV, 32'h8, 32'hF000_0000, '0, '0);         expect_reg(32'h00F0_0000, RD_NUM);
        stim(OP_SRAV, 32'h1, 32'hFFFF_FFFE, '0, '0);         expect_reg(32'hFFFF_FFFF, RD_NUM);
        stim(OP_CLZ, 32'h0, '0, '0, '0);                     expect_reg(32'd32, RD_NUM);
        stim(OP_CLZ, 32'h0001_0000, '0, '0, '0);             expect_reg(32'd15, RD_NUM);
        stim(OP_CLO, 32'hFFFF_FFFF, '0, '0, '0);             expect_reg(32'd32, RD_NUM);
        stim(OP_CLO, 32'hF000_0000, '0, '0, '0);             expect_reg(32'd4, RD_NUM);
        // -3 times 5, signed and unsigned
        stim(OP_MULT, 32'hFFFF_FFFD, 32'h5, '0, '0);         expect_hilo(64'hFFFF_FFFF_FFFF_FFF1);
        stim(OP_MULTU, 32'hFFFF_FFFD, 32'h5, '0, '0);        expect_hilo(64'h0000_0004_FFFF_FFF1);
        stim(OP_MUL, 32'hFFFF_FFFD, 32'h5, '0, '0);          expect_reg(32'hFFFF_FFF1, RD_NUM);
        stim(OP_MTHI, 32'hCAFE_0001, '0, '0, '0);            expect_hilo(64'hCAFE_0001_3333_4444);
        stim(OP_MTLO, 32'hCAFE_0001, '0, '0, '0);            expect_hilo(64'h1111_2222_CAFE_0001);
        stim(OP_MFHI, '0, '0, '0, '0);                       expect_reg(32'h1111_2222, RD_NUM);
        stim(OP_MFLO, '0, '0, '0, '0);                       expect_reg(32'h3333_4444, RD_NUM);
        // loads and stores, base 0x10000000
        mem_case(OP_LB, 16'hFFFC, 32'h0FFF_FFFC, MEM_M2R, MEM_BYTE, 1'b1);
        mem_case(OP_LBU, 16'h0010, 32'h1000_0010, MEM_M2R, MEM_BYTE, 1'b0);
        mem_case(OP_LH, 16'h8000, 32'h0FFF_8000, MEM_M2R, MEM_HALF, 1'b1);
        mem_case(OP_LHU, 16'h0002, 32'h1000_0002, MEM_M2R, MEM_HALF, 1'b0);
        mem_case(OP_LW, 16'h7FFC, 32'h1000_7FFC, MEM_M2R, MEM_WORD, 1'b1);
        mem_case(OP_LWL, 16'h0001, 32'h1000_0001, MEM_M2R, MEM_LEFT_WORD, 1'b1);
        mem_case(OP_LWR, 16'hFFFF, 32'h0FFF_FFFF, MEM_M2R, MEM_RIGHT_WORD, 1'b1);
        mem_case(OP_SB, 16'h0003, 32'h1000_0003, MEM_R2M, MEM_BYTE, 1'b1);
        mem_case(OP_SH, 16'hFFFE, 32'h0FFF_FFFE, MEM_R2M, MEM_HALF, 1'b1);
        mem_case(OP_SW, 16'h0040, 32'h1000_0040, MEM_R2M, MEM_WORD, 1'b1);
        mem_case(OP_SWL, 16'h0005, 32'h1000_0005, MEM_R2M, MEM_LEFT_WORD, 1'b1);
        mem_case(OP_SWR, 16'hFFF0, 32'h0FFF_FFF0, MEM_R2M, MEM_RIGHT_WORD, 1'b1);
        // link writes and conditional moves
        stim(OP_JAL, '0, '0, '0, '0);                        expect_reg(RET_ADDR, 5'd31);
        stim(OP_BGEZAL, '0, '0, '0, '0);                     expect_reg(RET_ADDR, 5'd31);
        stim(OP_BLTZAL, '0, '0, '0, '0);                     expect_reg(RET_ADDR, 5'd31);
        stim(OP_JALR, '0, '0, '0, '0);                       expect_reg(RET_ADDR, RD_NUM);
        stim(OP_MOVZ, 32'h1234, 32'h0, '0, '0);              expect_reg(32'h1234, RD_NUM);
        stim(OP_MOVZ, 32'h1234, 32'h1, '0, '0);              expect_reg(32'h1234, '0);
        stim(OP_MOVN, 32'h1234, 32'h1, '0, '0);              expect_reg(32'h1234, RD_NUM);
        stim(OP_MOVN, 32'h1234, 32'h0, '0, '0);              expect_reg(32'h1234, '0);
        stim(OP_NOP, 32'h55, 32'h66, '0, '0);
        // random addu/xor burst
        for (int k = 0; k < BURST_LEN; k++)
        begin
            take_bits(1, pick);
            take_bits(32, rnd_a);
            take_bits(32, rnd_b);
            take_bits(5, rnd_r);
            rnd_op = pick[0] ? OP_XOR : OP_ADDU;
            stim(rnd_op, rnd_a, rnd_b, '0, '0);
            tbl[n_entries-1].rd = rnd_r[4:0];
            expect_reg(model_alu(rnd_op, rnd_a, rnd_b), rnd_r[4:0]);
        end
    endtask

    task automatic drive(input entry_t e, input logic v);
        valid_i       = v;
        inst_i        = e.op;
        reg_s_val_i   = e.rs;
        reg_t_val_i   = e.rt;
        reg_d_i       = e.rd;
        reg_t_i       = e.rtn;
        immediate_i   = e.imm;
        shift_i       = e.sh;
        return_addr_i = e.ra;
        hilo_i        = e.hilo;
    endtask

    task automatic check_outputs(input string tag, input logic exp_valid, input entry_t e);
        check_flag(valid_o, exp_valid, {tag, " valid_o"});
        check_word(val_o, e.e_val, {tag, " val_o"});
        check_reg(dest_reg_o, e.e_dest, {tag, " dest_reg_o"});
        check_flag(overflow_o, e.e_ovf, {tag, " overflow_o"});
        check_hilo(hilo_o, hilo_we_o, e.e_hilo, e.e_we, {tag, " hilo"});
        check_mem(mem_type_o, mem_size_o, mem_signed_o, e.e_type, e.e_size, e.e_sgn, tag);
        check_word(mem_addr_o, e.e_addr, {tag, " mem_addr_o"});
    endtask

    initial
    begin
        lfsr      = 16'd62438;
        n_entries = 0;
        drive(default_entry(), 1'b0);
        build_table();

        wait_cnt = 0;
        while (rst_n !== 1'b1 && wait_cnt < RESET_TIMEOUT)
        begin
            @(negedge clk);
            wait_cnt++;
        end
        if (rst_n !== 1'b1)
        begin
            $display("reset never released within %0d cycles", RESET_TIMEOUT);
            $display("tests failed");
            $fatal(1, "reset timeout");
        end
        check_outputs("after reset", 1'b0, default_entry());

        // one strobe per cycle, each result checked on the next falling edge
        for (int i = 0; i < n_entries; i++)
        begin
            @(negedge clk);
            if (i > 0)
                check_outputs($sformatf("entry %0d %s", i - 1, tbl[i-1].op.name()),
                              1'b1, tbl[i-1]);
            drive(tbl[i], 1'b1);
        end
        @(negedge clk);
        check_outputs($sformatf("entry %0d %s", n_entries - 1, tbl[n_entries-1].op.name()),
                      1'b1, tbl[n_entries-1]);
        drive(default_entry(), 1'b0);
        @(negedge clk);
        check_outputs("after idle", 1'b0, default_entry());

        $display("all tests passed");
        $finish;
    end

endmodule

// ==== tb.f ====
design/ex_pkg.sv
design/ex_alu_arith.sv
design/ex_logic_shift.sv
design/ex_multiplier.sv
design/ex_mem_access.sv
design/ex_writeback.sv
design/ex_stage.sv
sim/tb_ex_stage.sv

// ==== run.sh ====
#!/bin/sh
# build with verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_ex_stage -f tb.f -o tb_ex_stage \
    && ./obj_dir/tb_ex_stage > sim.log 2>&1 \
    || echo "build or simulation returned an error"
cat sim.log 2>/dev/null
grep -q "all tests passed" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }
